// ==== tb.f ====
+incdir+.
nts_api_pkg.sv
nts_stats_pkg.sv
nts_api_decode.sv
nts_stat_counters.sv
nts_api_readmux.sv
nts_engine.sv
nts_engine_sva.sv
tb_nts_engine.sv

// ==== Bender.yml ====
package:
  name: nts_engine

export_include_dirs:
  - .

sources:
  - files:
      - nts_api_pkg.sv
      - nts_stats_pkg.sv
      - nts_api_decode.sv
      - nts_stat_counters.sv
      - nts_api_readmux.sv
      - nts_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - nts_engine_sva.sv
      - tb_nts_engine.sv

// ==== tb_nts_engine.sv ====
`timescale 1ns/1ps

`include "nts_engine_macros.svh"

module tb_nts_engine;

  import nts_api_pkg::*;
  import nts_stats_pkg::*;

  localparam realtime CLK_PERIOD = 4.0;
  localparam realtime WATCHDOG   = 100000.0; // Whole run, in ns

  // Every readable word of both blocks
  localparam api_addr_t MAPPED [18] = '{
    12'h000, 12'h001, 12'h002, 12'h008, 12'h100, 12'h101, 12'h102, 12'h103, 12'h104,
    12'h105, 12'h106, 12'h107, 12'h108, 12'h109, 12'h120, 12'h121, 12'h122, 12'h123
  };

  logic        clk = 1'b0;
  logic        areset;
  logic        api_cs;
  logic        api_we;
  api_addr_t   api_address;
  api_data_t   api_write_data;
  api_data_t   api_read_data;
  stat_vec_t   events;                   // Strobes in counter order

  counter_t    model_count [STAT_COUNT];
  half_t       model_snap  [STAT_COUNT];
  int unsigned model_cycle;              // Cycles since reset release
  int          test_errors;
  int          pass_count;
  int          fail_count;

  nts_engine dut0 (
    .i_clk               (clk),
    .i_areset            (areset),
    .i_api_cs            (api_cs),
    .i_api_we            (api_we),
    .i_api_address       (api_address),
    .i_api_write_data    (api_write_data),
    .o_api_read_data     (api_read_data),
    .i_stat_processed    (events[STAT_PROCESSED]),
    .i_stat_bad_cookie   (events[STAT_BAD_COOKIE]),
    .i_stat_bad_auth     (events[STAT_BAD_AUTH]),
    .i_stat_bad_keyid    (events[STAT_BAD_KEYID]),
    .i_stat_error_crypto (events[STAT_ERROR_CRYPTO]),
    .i_stat_error_txbuf  (events[STAT_ERROR_TXBUF])
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // MSB word of each counter, its LSB is the next word
  function automatic api_word_t msb_word(input int c);
    case (c)
      0:       msb_word = DBG_PROCESSED_MSB;
      1:       msb_word = DBG_BAD_COOKIE_MSB;
      2:       msb_word = DBG_BAD_AUTH_MSB;
      3:       msb_word = DBG_BAD_KEYID_MSB;
      4:       msb_word = DBG_ERROR_CRYPTO_MSB;
      default: msb_word = DBG_ERROR_TXBUF_MSB;
    endcase
  endfunction

  function automatic api_data_t expected_read(input logic cs, input logic we,
                                              input api_addr_t addr);
    api_word_t  w;
    logic [3:0] blk;
    w   = addr[7:0];
    blk = addr[11:8];
    expected_read = '0;
    if (cs && !we && blk == 4'h0)
    begin
      case (w)
        8'h00:   expected_read = `NTS_CORE_NAME0;
        8'h01:   expected_read = `NTS_CORE_NAME1;
        8'h02:   expected_read = `NTS_CORE_VERSION;
        8'h08:   expected_read = `NTS_CTRL_VALUE;
        default: ;
      endcase
    end
    else if (cs && !we && blk == 4'h1)
    begin
      if (w == 8'h08)
        expected_read = `NTS_DEBUG_NAME;
      if (w == 8'h09)
        expected_read = model_cycle + 1;
      for (int c = 0; c < STAT_COUNT; c++)
      begin
        if (w == msb_word(c))
          expected_read = model_count[c][63:32];
        if (w == msb_word(c) + 8'h1)
          expected_read = model_snap[c];
      end
    end
  endfunction

  // ------------------------------------------------------------
  // Reporting and cycle helpers
  // ------------------------------------------------------------

  task automatic report_mismatch(input string name, input api_data_t exp, input api_data_t act);
    $display("FAILED at %0t ps: %s expected %h got %h", $realtime, name, exp, act);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
      pass_count++;
      $display("Test %-10s passed", name);
    end
    else
    begin
      fail_count++;
      $display("Test %-10s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR: %s", reason);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wait_cycles(input int n);
    realtime start;
    int      edges;
    start = $realtime;
    edges = 0;
    while (edges < n)
    begin
      @(negedge clk);
      edges++;
      if ($realtime - start > (n + 1) * CLK_PERIOD)
        abort_run("clock falling edges did not arrive in time");
    end
  endtask

  // Entered and left on a falling edge
  task automatic do_cycle(input logic cs, input logic we, input api_addr_t addr,
                          input stat_vec_t ev, output api_data_t rd);
    api_data_t exp;
    api_cs         = cs;
    api_we         = we;
    api_address    = addr;
    api_write_data = $urandom;
    events         = ev;
    #(CLK_PERIOD * 0.375); // Just before the rising edge
    rd  = api_read_data;
    exp = expected_read(cs, we, addr);
    if (rd !== exp)
      report_mismatch("o_api_read_data", exp, rd);
    for (int c = 0; c < STAT_COUNT; c++)
    begin
      if (cs && !we && addr[11:8] == 4'h1 && addr[7:0] == msb_word(c))
        model_snap[c] = model_count[c][31:0]; // Before this cycle's event
      if (ev[c])
        model_count[c] = model_count[c] + 1;
    end
    model_cycle++;
    wait_cycles(1);
  endtask

  task automatic idle(input int n, input bit with_events);
    api_data_t rd;
    repeat (n)
      do_cycle(1'b0, 1'b0, api_addr_t'($urandom),
               with_events ? stat_vec_t'($urandom) : stat_vec_t'(0), rd);
  endtask

  task automatic read_word(input api_addr_t addr, output api_data_t rd);
    do_cycle(1'b1, 1'b0, addr, '0, rd);
  endtask

  task automatic check_identity();
    api_data_t rd;
    read_word(12'h000, rd);
    if (rd !== `NTS_CORE_NAME0)
      report_mismatch("o_api_read_data ENG_NAME0", `NTS_CORE_NAME0, rd);
    read_word(12'h001, rd);
    if (rd !== `NTS_CORE_NAME1)
      report_mismatch("o_api_read_data ENG_NAME1", `NTS_CORE_NAME1, rd);
    read_word(12'h002, rd);
    if (rd !== `NTS_CORE_VERSION)
      report_mismatch("o_api_read_data ENG_VERSION", `NTS_CORE_VERSION, rd);
    read_word(12'h008, rd);
    if (rd !== `NTS_CTRL_VALUE)
      report_mismatch("o_api_read_data ENG_CTRL", `NTS_CTRL_VALUE, rd);
    read_word(12'h108, rd);
    if (rd !== `NTS_DEBUG_NAME)
      report_mismatch("o_api_read_data DBG_NAME", `NTS_DEBUG_NAME, rd);
  endtask

  initial
  begin
    #(WATCHDOG);
    abort_run("watchdog expired before the tests completed");
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial
  begin
    api_data_t   rd;
    api_data_t   msb;
    api_data_t   held;
    api_data_t   first;
    api_addr_t   addr;
    int          k;
    int unsigned n;
    void'($urandom(32'h4964));
    areset         = 1'b1;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = '0;
    api_write_data = '0;
    events         = '0;
    for (int c = 0; c < STAT_COUNT; c++)
    begin
      model_count[c] = '0;
      model_snap[c]  = '0;
    end
    model_cycle = 0;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    wait_cycles(5);
    areset = 1'b0; // Systick reads 1 in this cycle

    check_identity();
    for (int i = 0; i < 30; i++)
    begin
      case (i % 3)
        0:       addr = {4'h2 + 4'($urandom_range(13)), 8'($urandom)};
        1:       addr = {4'h0, 8'h10 + 8'($urandom_range(8'hef))};
        default: addr = {4'h1, 8'h40 + 8'($urandom_range(8'hbf))};
      endcase
      read_word(addr, rd);
      if (rd !== '0)
        report_mismatch("o_api_read_data unmapped", '0, rd);
    end
    for (int i = 0; i < 18; i++)
    begin
      do_cycle(1'b0, 1'($urandom), MAPPED[i], '0, rd);
      if (rd !== '0)
        report_mismatch("o_api_read_data cs low", '0, rd);
    end
    finish_test("identity");

    idle(400, 1'b1);
    for (int c = 0; c < STAT_COUNT; c++)
    begin
      read_word({4'h1, msb_word(c)}, msb);
      read_word({4'h1, msb_word(c) + 8'h1}, rd);
      if (msb !== '0)
        report_mismatch("o_api_read_data counter MSB", '0, msb);
      if (rd !== model_count[c][31:0])
        report_mismatch("o_api_read_data counter LSB", model_count[c][31:0], rd);
    end
    finish_test("counting");

    for (int c = 0; c < STAT_COUNT; c++)
    begin
      held = model_count[c][31:0];
      do_cycle(1'b1, 1'b0, {4'h1, msb_word(c)}, stat_vec_t'($urandom), msb);
      idle(10 + $urandom_range(20), 1'b1);
      read_word({4'h1, msb_word(c) + 8'h1}, rd);
      if (rd !== held)
        report_mismatch("o_api_read_data held LSB", held, rd);
      read_word({4'h1, msb_word(c)}, msb);
      read_word({4'h1, msb_word(c) + 8'h1}, rd);
      if (rd !== model_count[c][31:0])
        report_mismatch("o_api_read_data fresh LSB", model_count[c][31:0], rd);
    end
    finish_test("snapshot");

    for (int i = 0; i < 54; i++)
      do_cycle(1'b1, 1'b1, MAPPED[i % 18], '0, rd); // Reads zero while we is high
    check_identity();
    for (int c = 0; c < STAT_COUNT; c++)
    begin
      read_word({4'h1, msb_word(c)}, msb);
      read_word({4'h1, msb_word(c) + 8'h1}, rd);
      held = model_count[c][31:0];
      if (rd !== held)
        report_mismatch("o_api_read_data LSB after writes", held, rd);
      idle(8, 1'b1);
      do_cycle(1'b1, 1'b1, {4'h1, msb_word(c)}, '0, rd);
      read_word({4'h1, msb_word(c) + 8'h1}, rd);
      if (rd !== held)
        report_mismatch("o_api_read_data LSB after MSB write", held, rd);
    end
    finish_test("writes");

    for (int i = 0; i < 5; i++)
    begin
      n = model_cycle;
      read_word(12'h109, first);
      if (first !== api_data_t'(n + 1))
        report_mismatch("o_api_read_data systick", api_data_t'(n + 1), first);
      k = 1 + $urandom_range(40);
      idle(k - 1, 1'b1);
      read_word(12'h109, rd);
      if (api_data_t'(rd - first) !== api_data_t'(k))
        report_mismatch("o_api_read_data systick step", api_data_t'(k), rd - first);
    end
    finish_test("systick");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== nts_engine_sva.sv ====
`timescale 1ns/1ps

module nts_engine_sva (
  input logic                     i_clk,
  input logic                     i_areset,
  input nts_stats_pkg::stat_vec_t i_events,
  input nts_stats_pkg::stat_vec_t i_snapshot,
  input nts_stats_pkg::counter_t  i_counter      [nts_stats_pkg::STAT_COUNT],
  input nts_stats_pkg::half_t     i_snapshot_reg [nts_stats_pkg::STAT_COUNT],
  input nts_stats_pkg::systick_t  i_systick
);

  import nts_stats_pkg::*;

  localparam int HALF_W = $bits(half_t);

  // ------------------------------------------------------------
  // Event counters and their snapshots
  // ------------------------------------------------------------

  for (genvar g = 0; g < STAT_COUNT; g++)
  begin : g_stat
    a_count_step : assert property (@(posedge i_clk) disable iff (i_areset)
      i_events[g] |=> i_counter[g] == $past(i_counter[g]) + 1'b1)
      else $error("Counter %0d did not step by one after its event", g);

    a_count_hold : assert property (@(posedge i_clk) disable iff (i_areset)
      !i_events[g] |=> $stable(i_counter[g]))
      else $error("Counter %0d moved without an event", g);

    // Low half as it was during the MSB read
    a_snapshot_load : assert property (@(posedge i_clk) disable iff (i_areset)
      i_snapshot[g] |=> i_snapshot_reg[g] == $past(i_counter[g][HALF_W-1:0]))
      else $error("Snapshot %0d does not hold the previous low half", g);
  end

  // Wraps at 32 bits like the register itself
  a_systick_step : assert property (@(posedge i_clk) disable iff (i_areset)
    1'b1 |=> i_systick == $past(i_systick) + 1'b1)
    else $error("Systick did not advance by one");

endmodule

bind nts_stat_counters nts_engine_sva sva0 (
  .i_clk          (i_clk),
  .i_areset       (i_areset),
  .i_events       (i_events),
  .i_snapshot     (i_snapshot),
  .i_counter      (counter_q),
  .i_snapshot_reg (snapshot_q),
  .i_systick      (systick_q)
);

// ==== nts_engine.sv ====
`timescale 1ns/1ps

module nts_engine (
  input  logic                   i_clk,
  input  logic                   i_areset,

  input  logic                   i_api_cs,
  input  logic                   i_api_we,
  input  nts_api_pkg::api_addr_t i_api_address,
  input  nts_api_pkg::api_data_t i_api_write_data, // No writable registers
  output nts_api_pkg::api_data_t o_api_read_data,

  input  logic                   i_stat_processed,
  input  logic                   i_stat_bad_cookie,
  input  logic                   i_stat_bad_auth,
  input  logic                   i_stat_bad_keyid,
  input  logic                   i_stat_error_crypto,
  input  logic                   i_stat_error_txbuf
);

  import nts_api_pkg::*;
  import nts_stats_pkg::*;

  logic      block_engine;
  logic      block_debug;
  api_word_t word;
  stat_vec_t events;
  stat_vec_t snapshot;
  half_t     counter_msb [STAT_COUNT];
  half_t     counter_lsb [STAT_COUNT];
  systick_t  systick;

  // Strobes packed in counter order
  assign events[STAT_PROCESSED]    = i_stat_processed;
  assign events[STAT_BAD_COOKIE]   = i_stat_bad_cookie;
  assign events[STAT_BAD_AUTH]     = i_stat_bad_auth;
  assign events[STAT_BAD_KEYID]    = i_stat_bad_keyid;
  assign events[STAT_ERROR_CRYPTO] = i_stat_error_crypto;
  assign events[STAT_ERROR_TXBUF]  = i_stat_error_txbuf;

  nts_api_decode api_decode (
    .i_api_cs       (i_api_cs),
    .i_api_we       (i_api_we),
    .i_api_address  (i_api_address),
    .o_block_engine (block_engine),
    .o_block_debug  (block_debug),
    .o_word         (word),
    .o_snapshot     (snapshot)
  );

  nts_stat_counters stat_counters (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_events      (events),
    .i_snapshot    (snapshot),
    .o_counter_msb (counter_msb),
    .o_counter_lsb (counter_lsb),
    .o_systick     (systick)
  );

  nts_api_readmux api_readmux (
    .i_block_engine  (block_engine),
    .i_block_debug   (block_debug),
    .i_word          (word),
    .i_counter_msb   (counter_msb),
    .i_counter_lsb   (counter_lsb),
    .i_systick       (systick),
    .o_api_read_data (o_api_read_data)
  );

endmodule

// ==== nts_api_readmux.sv ====
`timescale 1ns/1ps

`include "nts_engine_macros.svh"

module nts_api_readmux (
  input  logic                    i_block_engine,
  input  logic                    i_block_debug,
  input  nts_api_pkg::api_word_t  i_word,
  input  nts_stats_pkg::half_t    i_counter_msb [nts_stats_pkg::STAT_COUNT],
  input  nts_stats_pkg::half_t    i_counter_lsb [nts_stats_pkg::STAT_COUNT],
  input  nts_stats_pkg::systick_t i_systick,
  output nts_api_pkg::api_data_t  o_api_read_data
);

  import nts_api_pkg::*;
  import nts_stats_pkg::*;

  api_data_t engine_data;
  api_data_t debug_data;

  // ------------------------------------------------------------
  // Engine identity block
  // ------------------------------------------------------------

  always_comb
  begin
    engine_data = '0;
    if (i_block_engine)
    begin
      case (i_word)
        ENG_NAME0:   engine_data = `NTS_CORE_NAME0;
        ENG_NAME1:   engine_data = `NTS_CORE_NAME1;
        ENG_VERSION: engine_data = `NTS_CORE_VERSION;
        ENG_CTRL:    engine_data = `NTS_CTRL_VALUE;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Debug block
  // ------------------------------------------------------------

  always_comb
  begin
    debug_data = '0;
    if (i_block_debug)
    begin
      case (i_word)
        DBG_PROCESSED_MSB:    debug_data = i_counter_msb[STAT_PROCESSED];
        DBG_PROCESSED_LSB:    debug_data = i_counter_lsb[STAT_PROCESSED];
        DBG_BAD_COOKIE_MSB:   debug_data = i_counter_msb[STAT_BAD_COOKIE];
        DBG_BAD_COOKIE_LSB:   debug_data = i_counter_lsb[STAT_BAD_COOKIE];
        DBG_BAD_AUTH_MSB:     debug_data = i_counter_msb[STAT_BAD_AUTH];
        DBG_BAD_AUTH_LSB:     debug_data = i_counter_lsb[STAT_BAD_AUTH];
        DBG_BAD_KEYID_MSB:    debug_data = i_counter_msb[STAT_BAD_KEYID];
        DBG_BAD_KEYID_LSB:    debug_data = i_counter_lsb[STAT_BAD_KEYID];
        DBG_NAME:             debug_data = `NTS_DEBUG_NAME;
        DBG_SYSTICK:          debug_data = i_systick;
        DBG_ERROR_CRYPTO_MSB: debug_data = i_counter_msb[STAT_ERROR_CRYPTO];
        DBG_ERROR_CRYPTO_LSB: debug_data = i_counter_lsb[STAT_ERROR_CRYPTO];
        DBG_ERROR_TXBUF_MSB:  debug_data = i_counter_msb[STAT_ERROR_TXBUF];
        DBG_ERROR_TXBUF_LSB:  debug_data = i_counter_lsb[STAT_ERROR_TXBUF];
        default: ;
      endcase
    end
  end

  // At most one block is selected, the other contributes zero
  assign o_api_read_data = engine_data | debug_data;

endmodule

// ==== nts_stat_counters.sv ====
`timescale 1ns/1ps

`include "nts_engine_macros.svh"

module nts_stat_counters (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  nts_stats_pkg::stat_vec_t i_events,
  input  nts_stats_pkg::stat_vec_t i_snapshot,
  output nts_stats_pkg::half_t     o_counter_msb [nts_stats_pkg::STAT_COUNT],
  output nts_stats_pkg::half_t     o_counter_lsb [nts_stats_pkg::STAT_COUNT],
  output nts_stats_pkg::systick_t  o_systick
);

  import nts_stats_pkg::*;

  localparam int HALF_W = $bits(half_t);

  counter_t counter_q  [STAT_COUNT]; // Live event counts
  half_t    snapshot_q [STAT_COUNT]; // Low half captured on MSB read
  systick_t systick_q;

  // ------------------------------------------------------------
  // Event counters
  // ------------------------------------------------------------

  for (genvar g = 0; g < STAT_COUNT; g++)
  begin : g_counter

    always_ff @(posedge i_clk or posedge i_areset)
    begin
      if (i_areset)
      begin
        counter_q[g] <= '0;
      end
      else if (i_events[g])
      begin
        counter_q[g] <= counter_q[g] + 1'b1;
      end
    end

    // Takes the value seen during the MSB read, before any same-cycle event
    always_ff @(posedge i_clk or posedge i_areset)
    begin
      if (i_areset)
      begin
        snapshot_q[g] <= '0;
      end
      else if (i_snapshot[g])
      begin
        snapshot_q[g] <= counter_q[g][HALF_W-1:0];
      end
    end

    assign o_counter_msb[g] = counter_q[g][`NTS_COUNTER_W-1 -: HALF_W];
    assign o_counter_lsb[g] = snapshot_q[g]; // Never the live low half

  end

  // ------------------------------------------------------------
  // Systick
  // ------------------------------------------------------------

  // Free running, wraps at full width
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      systick_q <= `NTS_SYSTICK_RESET;
    end
    else
    begin
      systick_q <= systick_q + 1'b1;
    end
  end

  assign o_systick = systick_q;

endmodule

// ==== nts_api_decode.sv ====
`timescale 1ns/1ps

`include "nts_engine_macros.svh"

module nts_api_decode (
  input  logic                     i_api_cs,
  input  logic                     i_api_we,
  input  nts_api_pkg::api_addr_t   i_api_address,
  output logic                     o_block_engine,
  output logic                     o_block_debug,
  output nts_api_pkg::api_word_t   o_word,
  output nts_stats_pkg::stat_vec_t o_snapshot
);

  import nts_api_pkg::*;
  import nts_stats_pkg::*;

  logic                    api_read;
  logic [`NTS_BLOCK_W-1:0] block;

  // ------------------------------------------------------------
  // Address split and block select
  // ------------------------------------------------------------

  assign api_read = i_api_cs & ~i_api_we; // Writes select nothing

  assign block  = i_api_address[`NTS_API_ADDR_W-1:`NTS_WORD_W];
  assign o_word = i_api_address[`NTS_WORD_W-1:0];

  assign o_block_engine = api_read && (block == BLOCK_ENGINE);
  assign o_block_debug  = api_read && (block == BLOCK_DEBUG);

  // ------------------------------------------------------------
  // Snapshot strobes
  // ------------------------------------------------------------

  // An MSB read latches the low half for the following LSB read
  always_comb
  begin
    o_snapshot = '0;
    if (o_block_debug)
    begin
      case (o_word)
        DBG_PROCESSED_MSB:    o_snapshot[STAT_PROCESSED]    = 1'b1;
        DBG_BAD_COOKIE_MSB:   o_snapshot[STAT_BAD_COOKIE]   = 1'b1;
        DBG_BAD_AUTH_MSB:     o_snapshot[STAT_BAD_AUTH]     = 1'b1;
        DBG_BAD_KEYID_MSB:    o_snapshot[STAT_BAD_KEYID]    = 1'b1;
        DBG_ERROR_CRYPTO_MSB: o_snapshot[STAT_ERROR_CRYPTO] = 1'b1;
        DBG_ERROR_TXBUF_MSB:  o_snapshot[STAT_ERROR_TXBUF]  = 1'b1;
        default: ; // LSB, name and systick words take no snapshot
      endcase
    end
  end

endmodule

// ==== nts_stats_pkg.sv ====
`include "nts_engine_macros.svh"

package nts_stats_pkg;

  // Event counters in strobe order
  typedef enum logic [2:0] {
    STAT_PROCESSED    = 3'd0,
    STAT_BAD_COOKIE   = 3'd1,
    STAT_BAD_AUTH     = 3'd2,
    STAT_BAD_KEYID    = 3'd3,
    STAT_ERROR_CRYPTO = 3'd4,
    STAT_ERROR_TXBUF  = 3'd5
  } stat_counter_e;

  parameter int STAT_COUNT = 6;

  typedef logic [STAT_COUNT-1:0] stat_vec_t; // One bit per counter

  typedef logic [`NTS_COUNTER_W-1:0]   counter_t;
  typedef logic [`NTS_COUNTER_W/2-1:0] half_t;    // One bus word of a counter

  // Free-running tick, read as a single bus word
  typedef logic [`NTS_API_DATA_W-1:0] systick_t;

endpackage

// ==== nts_api_pkg.sv ====
`include "nts_engine_macros.svh"

package nts_api_pkg;

  typedef logic [`NTS_API_ADDR_W-1:0] api_addr_t;
  typedef logic [`NTS_API_DATA_W-1:0] api_data_t;
  typedef logic [`NTS_WORD_W-1:0]     api_word_t; // Word field of the address

  // Upper address bits, anything else is unmapped
  typedef enum logic [`NTS_BLOCK_W-1:0] {
    BLOCK_ENGINE = 4'h0,
    BLOCK_DEBUG  = 4'h1
  } api_block_e;

  typedef enum logic [`NTS_WORD_W-1:0] {
    ENG_NAME0   = 8'h00,
    ENG_NAME1   = 8'h01,
    ENG_VERSION = 8'h02,
    ENG_CTRL    = 8'h08
  } engine_word_e;

  // Counters sit as MSB/LSB pairs, MSB on the even word
  typedef enum logic [`NTS_WORD_W-1:0] {
    DBG_PROCESSED_MSB    = 8'h00, DBG_PROCESSED_LSB    = 8'h01,
    DBG_BAD_COOKIE_MSB   = 8'h02, DBG_BAD_COOKIE_LSB   = 8'h03,
    DBG_BAD_AUTH_MSB     = 8'h04, DBG_BAD_AUTH_LSB     = 8'h05,
    DBG_BAD_KEYID_MSB    = 8'h06, DBG_BAD_KEYID_LSB    = 8'h07,
    DBG_NAME             = 8'h08,
    DBG_SYSTICK          = 8'h09,
    DBG_ERROR_CRYPTO_MSB = 8'h20, DBG_ERROR_CRYPTO_LSB = 8'h21,
    DBG_ERROR_TXBUF_MSB  = 8'h22, DBG_ERROR_TXBUF_LSB  = 8'h23
  } debug_word_e;

endpackage

// ==== nts_engine_macros.svh ====
`ifndef NTS_ENGINE_MACROS_SVH
`define NTS_ENGINE_MACROS_SVH

// ------------------------------------------------------------
// API bus geometry
// ------------------------------------------------------------

`define NTS_API_ADDR_W 12 // External address width
`define NTS_API_DATA_W 32 // Read and write data width

// Address splits into block (11..8) and word (7..0)
`define NTS_BLOCK_W 4
`define NTS_WORD_W  8

// ------------------------------------------------------------
// Identity words
// ------------------------------------------------------------

`define NTS_CORE_NAME0   32'h4e_54_53_5f // "NTS_"
`define NTS_CORE_NAME1   32'h45_4e_47_4e // "ENGN"
`define NTS_CORE_VERSION 32'h30_2e_30_33 // "0.03"
`define NTS_DEBUG_NAME   32'h44_42_55_47 // "DBUG"

// Control word always reads back as one
`define NTS_CTRL_VALUE 32'h0000_0001

// ------------------------------------------------------------
// Debug block
// ------------------------------------------------------------

`define NTS_SYSTICK_RESET 32'h0000_0001 // First cycle out of reset reads 1
`define NTS_COUNTER_W     64            // Event counter width

`endif
